// ==== ex_pkg.sv ====
package ex_pkg;

    // data and address width of the core
    localparam int XLEN = 32;

    // operation codes, grouped by execution unit so the class
    // can be read straight from the encoding
    typedef enum logic [4:0] {
        // single-cycle integer unit
        OP_NOP    = 5'd0,
        OP_ADD    = 5'd1,
        OP_SUB    = 5'd2,
        OP_SLT    = 5'd3,
        OP_SLTU   = 5'd4,
        OP_AND    = 5'd5,
        OP_OR     = 5'd6,
        OP_XOR    = 5'd7,
        OP_NOR    = 5'd8,
        OP_SLL    = 5'd9,
        OP_SRL    = 5'd10,
        OP_SRA    = 5'd11,
        // multiplier
        OP_MULW   = 5'd12,
        OP_MULHW  = 5'd13,
        OP_MULHWU = 5'd14,
        // divider
        OP_DIVW   = 5'd15,
        OP_MODW   = 5'd16,
        OP_DIVWU  = 5'd17,
        OP_MODWU  = 5'd18,
        // branch unit
        OP_BEQ    = 5'd19,
        OP_BNE    = 5'd20,
        OP_BLT    = 5'd21,
        OP_BGE    = 5'd22,
        OP_BLTU   = 5'd23,
        OP_BGEU   = 5'd24,
        OP_JIRL   = 5'd25,
        // load/store
        OP_LDB    = 5'd26,
        OP_LDH    = 5'd27,
        OP_LDW    = 5'd28,
        OP_STB    = 5'd29,
        OP_STH    = 5'd30,
        OP_STW    = 5'd31
    } alu_op_e;

endpackage

// ==== regular_alu.sv ====
`timescale 1ns/1ns

module regular_alu (
    input  ex_pkg::alu_op_e          op_i,
    input  logic [ex_pkg::XLEN-1:0]  a_i,
    input  logic [ex_pkg::XLEN-1:0]  b_i,
    output logic [ex_pkg::XLEN-1:0]  result_o
);

    logic [4:0]             shamt;
    logic [ex_pkg::XLEN-1:0] sum;
    logic [ex_pkg::XLEN-1:0] diff;

    // only the low five bits count for a 32-bit shift
    assign shamt = b_i[4:0];
    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;

    always_comb begin
        case (op_i)
            ex_pkg::OP_ADD: begin
                result_o = sum;
            end
            ex_pkg::OP_SUB: begin
                result_o = diff;
            end
            ex_pkg::OP_SLT: begin
                result_o = {{(ex_pkg::XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            end
            ex_pkg::OP_SLTU: begin
                result_o = {{(ex_pkg::XLEN-1){1'b0}}, a_i < b_i};
            end
            ex_pkg::OP_AND: begin
                result_o = a_i & b_i;
            end
            ex_pkg::OP_OR: begin
                result_o = a_i | b_i;
            end
            ex_pkg::OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            ex_pkg::OP_NOR: begin
                result_o = ~(a_i | b_i);
            end
            ex_pkg::OP_SLL: begin
                result_o = a_i << shamt;
            end
            ex_pkg::OP_SRL: begin
                result_o = a_i >> shamt;
            end
            ex_pkg::OP_SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== mul_alu.sv ====
`timescale 1ns/1ns

module mul_alu #(
    parameter int MUL_LATENCY = 2
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  logic                       signed_i,
    input  logic [ex_pkg::XLEN-1:0]    a_i,
    input  logic [ex_pkg::XLEN-1:0]    b_i,
    output logic                       done_o,
    output logic [2*ex_pkg::XLEN-1:0]  product_o
);

    logic signed [ex_pkg::XLEN:0]       a_ext;
    logic signed [ex_pkg::XLEN:0]       b_ext;
    logic signed [2*ex_pkg::XLEN+1:0]   full_prod;
    logic [MUL_LATENCY-1:0]             valid_q;
    logic [2*ex_pkg::XLEN-1:0]          prod_q [MUL_LATENCY];

    // extra top bit makes one signed multiply serve both flavours
    assign a_ext     = {signed_i & a_i[ex_pkg::XLEN-1], a_i};
    assign b_ext     = {signed_i & b_i[ex_pkg::XLEN-1], b_i};
    assign full_prod = a_ext * b_ext;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= start_i;
            for (int i = 1; i < MUL_LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // product pipe, one entry per stage
    always_ff @(posedge clk) begin
        prod_q[0] <= full_prod[2*ex_pkg::XLEN-1:0];
        for (int i = 1; i < MUL_LATENCY; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign done_o    = valid_q[MUL_LATENCY-1];
    assign product_o = prod_q[MUL_LATENCY-1];

    // back-to-back results only come from back-to-back starts
    a_done_pair: assert property (@(posedge clk) disable iff (rst_i)
        (done_o && $past(done_o)) |-> $past(start_i, MUL_LATENCY + 1));

endmodule

// ==== div_alu.sv ====
`timescale 1ns/1ns

module div_alu (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic                     signed_i,
    input  logic [ex_pkg::XLEN-1:0]  dividend_i,
    input  logic [ex_pkg::XLEN-1:0]  divisor_i,
    output logic                     busy_o,
    output logic                     done_o,
    output logic [ex_pkg::XLEN-1:0]  quotient_o,
    output logic [ex_pkg::XLEN-1:0]  remainder_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_FINISH
    } div_state_e;

    div_state_e              state_q;
    logic [4:0]              step_q;
    logic                    quo_neg_q;
    logic                    rem_neg_q;
    logic [ex_pkg::XLEN-1:0] quo_q;
    logic [ex_pkg::XLEN-1:0] rem_q;
    logic [ex_pkg::XLEN-1:0] div_mag_q;
    logic                    a_neg;
    logic                    b_neg;
    logic [ex_pkg::XLEN-1:0] a_mag;
    logic [ex_pkg::XLEN-1:0] b_mag;
    logic [ex_pkg::XLEN:0]   rem_shift;
    logic                    fits;

    assign a_neg = signed_i & dividend_i[ex_pkg::XLEN-1];
    assign b_neg = signed_i & divisor_i[ex_pkg::XLEN-1];
    assign a_mag = a_neg ? -dividend_i : dividend_i;
    assign b_mag = b_neg ? -divisor_i : divisor_i;

    // one restoring step, next dividend bit shifted in from the quotient
    assign rem_shift = {rem_q, quo_q[ex_pkg::XLEN-1]};
    assign fits      = rem_shift >= {1'b0, div_mag_q};

    // control state
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        step_q  <= '0;
                        state_q <= (divisor_i == '0) ? S_FINISH : S_RUN;
                    end
                end
                S_RUN: begin
                    step_q <= step_q + 5'd1;
                    if (step_q == 5'd31) begin
                        state_q <= S_FINISH;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start_i) begin
            div_mag_q <= b_mag;
            if (divisor_i == '0) begin
                // result is final straight away
                quo_q     <= '1;
                rem_q     <= dividend_i;
                quo_neg_q <= 1'b0;
                rem_neg_q <= 1'b0;
            end else begin
                quo_q     <= a_mag;
                rem_q     <= '0;
                quo_neg_q <= a_neg ^ b_neg;
                rem_neg_q <= a_neg;
            end
        end else if (state_q == S_RUN) begin
            quo_q <= {quo_q[ex_pkg::XLEN-2:0], fits};
            if (fits) begin
                rem_q <= rem_shift[ex_pkg::XLEN-1:0] - div_mag_q;
            end else begin
                rem_q <= rem_shift[ex_pkg::XLEN-1:0];
            end
        end
    end

    assign busy_o      = (state_q != S_IDLE);
    assign done_o      = (state_q == S_FINISH);
    assign quotient_o  = quo_neg_q ? -quo_q : quo_q;
    assign remainder_o = rem_neg_q ? -rem_q : rem_q;

    // the issuing stage must wait for the previous division
    a_no_restart: assert property (@(posedge clk) disable iff (rst_i)
        start_i |-> !busy_o);

endmodule

// ==== branch_alu.sv ====
`timescale 1ns/1ns

module branch_alu (
    input  ex_pkg::alu_op_e          op_i,
    input  logic [ex_pkg::XLEN-1:0]  pc_i,
    input  logic [ex_pkg::XLEN-1:0]  a_i,
    input  logic [ex_pkg::XLEN-1:0]  b_i,
    input  logic [ex_pkg::XLEN-1:0]  imm_i,
    input  logic                     pred_taken_i,
    input  logic [ex_pkg::XLEN-1:0]  pred_target_i,
    output logic                     taken_o,
    output logic [ex_pkg::XLEN-1:0]  target_o,
    output logic [ex_pkg::XLEN-1:0]  link_o,
    output logic                     mispredict_o
);

    logic is_branch;
    logic cond;

    always_comb begin
        is_branch = 1'b1;
        case (op_i)
            ex_pkg::OP_BEQ: begin
                cond = (a_i == b_i);
            end
            ex_pkg::OP_BNE: begin
                cond = (a_i != b_i);
            end
            ex_pkg::OP_BLT: begin
                cond = ($signed(a_i) < $signed(b_i));
            end
            ex_pkg::OP_BGE: begin
                cond = ($signed(a_i) >= $signed(b_i));
            end
            ex_pkg::OP_BLTU: begin
                cond = (a_i < b_i);
            end
            ex_pkg::OP_BGEU: begin
                cond = (a_i >= b_i);
            end
            ex_pkg::OP_JIRL: begin
                cond = 1'b1;
            end
            default: begin
                is_branch = 1'b0;
                cond      = 1'b0;
            end
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target_o = (op_i == ex_pkg::OP_JIRL) ? (a_i + imm_i) : (pc_i + imm_i);
    assign link_o   = pc_i + 32'd4;
    assign taken_o  = is_branch & cond;

    assign mispredict_o = is_branch &
                          ((taken_o != pred_taken_i) ||
                           (taken_o && (target_o != pred_target_i)));

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage #(
    parameter int MUL_LATENCY = 2
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     issue_valid_i,
    input  ex_pkg::alu_op_e          issue_op_i,
    input  logic [ex_pkg::XLEN-1:0]  issue_pc_i,
    input  logic [ex_pkg::XLEN-1:0]  issue_rs1_i,
    input  logic [ex_pkg::XLEN-1:0]  issue_rs2_i,
    input  logic [ex_pkg::XLEN-1:0]  issue_imm_i,
    input  logic [4:0]               issue_rd_i,
    input  logic                     pred_taken_i,
    input  logic [ex_pkg::XLEN-1:0]  pred_target_i,
    input  logic                     mem_addr_ok_i,
    output logic                     stall_o,
    output logic                     wb_valid_o,
    output logic [4:0]               wb_rd_o,
    output logic [ex_pkg::XLEN-1:0]  wb_data_o,
    output logic                     redirect_o,
    output logic [ex_pkg::XLEN-1:0]  redirect_target_o,
    output logic                     mem_valid_o,
    output logic                     mem_we_o,
    output logic [ex_pkg::XLEN-1:0]  mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]  mem_wdata_o,
    output logic [3:0]               mem_wstrb_o,
    output logic                     exc_ale_o
);

    logic is_alu, is_mul, is_div, is_br, is_mem, is_store, misalign;

    // operation class
    assign is_alu   = issue_op_i inside {[ex_pkg::OP_ADD : ex_pkg::OP_SRA]};
    assign is_mul   = issue_op_i inside {[ex_pkg::OP_MULW : ex_pkg::OP_MULHWU]};
    assign is_div   = issue_op_i inside {[ex_pkg::OP_DIVW : ex_pkg::OP_MODWU]};
    assign is_br    = issue_op_i inside {[ex_pkg::OP_BEQ : ex_pkg::OP_JIRL]};
    assign is_mem   = issue_op_i inside {[ex_pkg::OP_LDB : ex_pkg::OP_STW]};
    assign is_store = issue_op_i inside {ex_pkg::OP_STB, ex_pkg::OP_STH, ex_pkg::OP_STW};

    logic [ex_pkg::XLEN-1:0] alu_res;

    regular_alu u_regular_alu (
        .op_i     (issue_op_i),
        .a_i      (issue_rs1_i),
        .b_i      (issue_rs2_i),
        .result_o (alu_res)
    );

    // one start pulse per multiply
    logic                      mul_launch, mul_start_q, mul_wait_q, mul_signed_q, mul_done;
    logic [ex_pkg::XLEN-1:0]   mul_a_q, mul_b_q, mul_res;
    logic [2*ex_pkg::XLEN-1:0] mul_product;

    assign mul_launch = issue_valid_i && is_mul && !mul_start_q && !mul_wait_q && !mul_done;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mul_start_q <= 1'b0;
            mul_wait_q  <= 1'b0;
        end else begin
            mul_start_q <= mul_launch;
            if (mul_start_q) begin
                mul_wait_q <= 1'b1;
            end else if (mul_done) begin
                mul_wait_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_launch) begin
            mul_a_q      <= issue_rs1_i;
            mul_b_q      <= issue_rs2_i;
            mul_signed_q <= (issue_op_i != ex_pkg::OP_MULHWU);
        end
    end

    mul_alu #(
        .MUL_LATENCY (MUL_LATENCY)
    ) u_mul_alu (
        .clk       (clk),
        .rst_i     (rst_i),
        .start_i   (mul_start_q),
        .signed_i  (mul_signed_q),
        .a_i       (mul_a_q),
        .b_i       (mul_b_q),
        .done_o    (mul_done),
        .product_o (mul_product)
    );

    assign mul_res = (issue_op_i == ex_pkg::OP_MULW) ? mul_product[ex_pkg::XLEN-1:0]
                                                      : mul_product[2*ex_pkg::XLEN-1:ex_pkg::XLEN];

    // divide launch
    logic                    div_launch, div_start_q, div_signed_q, div_busy, div_done;
    logic [ex_pkg::XLEN-1:0] div_a_q, div_b_q, div_quo, div_rem, div_res;

    assign div_launch = issue_valid_i && is_div && !div_start_q && !div_busy && !div_done;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            div_start_q <= 1'b0;
        end else begin
            div_start_q <= div_launch;
        end
    end

    always_ff @(posedge clk) begin
        if (div_launch) begin
            div_a_q      <= issue_rs1_i;
            div_b_q      <= issue_rs2_i;
            div_signed_q <= issue_op_i inside {ex_pkg::OP_DIVW, ex_pkg::OP_MODW};
        end
    end

    div_alu u_div_alu (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (div_start_q),
        .signed_i    (div_signed_q),
        .dividend_i  (div_a_q),
        .divisor_i   (div_b_q),
        .busy_o      (div_busy),
        .done_o      (div_done),
        .quotient_o  (div_quo),
        .remainder_o (div_rem)
    );

    assign div_res = issue_op_i inside {ex_pkg::OP_DIVW, ex_pkg::OP_DIVWU} ? div_quo : div_rem;

    logic                    br_taken, br_mispredict;
    logic [ex_pkg::XLEN-1:0] br_target, br_link;

    branch_alu u_branch_alu (
        .op_i          (issue_op_i),
        .pc_i          (issue_pc_i),
        .a_i           (issue_rs1_i),
        .b_i           (issue_rs2_i),
        .imm_i         (issue_imm_i),
        .pred_taken_i  (pred_taken_i),
        .pred_target_i (pred_target_i),
        .taken_o       (br_taken),
        .target_o      (br_target),
        .link_o        (br_link),
        .mispredict_o  (br_mispredict)
    );

    // load/store address and lanes
    assign mem_addr_o = issue_rs1_i + issue_imm_i;

    always_comb begin
        misalign    = 1'b0;
        mem_wdata_o = '0;
        mem_wstrb_o = 4'b1111;
        case (issue_op_i)
            ex_pkg::OP_LDH: begin
                misalign = mem_addr_o[0];
            end
            ex_pkg::OP_LDW: begin
                misalign = (mem_addr_o[1:0] != 2'b00);
            end
            ex_pkg::OP_STB: begin
                mem_wdata_o = {4{issue_rs2_i[7:0]}};
                mem_wstrb_o = 4'b0001 << mem_addr_o[1:0];
            end
            ex_pkg::OP_STH: begin
                misalign    = mem_addr_o[0];
                mem_wdata_o = {2{issue_rs2_i[15:0]}};
                mem_wstrb_o = mem_addr_o[1] ? 4'b1100 : 4'b0011;
            end
            ex_pkg::OP_STW: begin
                misalign    = (mem_addr_o[1:0] != 2'b00);
                mem_wdata_o = issue_rs2_i;
            end
            default: begin
                misalign = 1'b0;
            end
        endcase
    end

    assign mem_we_o    = is_store;
    assign mem_valid_o = issue_valid_i && is_mem && !misalign;
    assign exc_ale_o   = issue_valid_i && is_mem && misalign;

    // hold the slot while a unit is busy or the cache refuses
    assign stall_o = (issue_valid_i && is_mul && !mul_done) ||
                     (issue_valid_i && is_div && !div_done) ||
                     (mem_valid_o && !mem_addr_ok_i);

    always_comb begin
        if (is_mul) begin
            wb_data_o = mul_res;
        end else if (is_div) begin
            wb_data_o = div_res;
        end else if (is_br) begin
            wb_data_o = br_link;
        end else begin
            wb_data_o = alu_res;
        end
    end

    assign wb_valid_o = issue_valid_i && !stall_o &&
                        (is_alu || is_mul || is_div || issue_op_i == ex_pkg::OP_JIRL);
    assign wb_rd_o    = issue_rd_i;

    assign redirect_o        = issue_valid_i && br_mispredict;
    assign redirect_target_o = br_taken ? br_target : br_link;

    // a refused request stays on the bus unchanged
    a_mem_held: assert property (@(posedge clk) disable iff (rst_i)
        (mem_valid_o && !mem_addr_ok_i) |=>
            (mem_valid_o && $stable(mem_addr_o) && $stable(mem_wdata_o) &&
             $stable(mem_wstrb_o)));

    // every unit result finds its operation still in the slot
    a_done_claimed: assert property (@(posedge clk) disable iff (rst_i)
        (mul_done || div_done) |-> (issue_valid_i && (is_mul || is_div)));

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_o
);

    initial begin
        clk   = 1'b0;
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        // release just after the edge, like the other stimulus
        #1 rst_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== ex_stage_tb.sv ====
`timescale 1ns/1ns

module ex_stage_tb;

    localparam int MUL_LATENCY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS      = 400;
    localparam int MAX_CYCLES   = NUM_OPS * (40 + MUL_LATENCY) + RESET_CYCLES;

    logic                    clk;
    logic                    rst_i;
    logic                    issue_valid_i;
    ex_pkg::alu_op_e         issue_op_i;
    logic [ex_pkg::XLEN-1:0] issue_pc_i, issue_rs1_i, issue_rs2_i, issue_imm_i;
    logic [4:0]              issue_rd_i;
    logic                    pred_taken_i;
    logic [ex_pkg::XLEN-1:0] pred_target_i;
    logic                    mem_addr_ok_i;
    logic                    stall_o, wb_valid_o, redirect_o;
    logic [4:0]              wb_rd_o;
    logic [ex_pkg::XLEN-1:0] wb_data_o, redirect_target_o;
    logic                    mem_valid_o, mem_we_o, exc_ale_o;
    logic [ex_pkg::XLEN-1:0] mem_addr_o, mem_wdata_o;
    logic [3:0]              mem_wstrb_o;

    logic [31:0] rng_state;
    int          cycle_cnt = 0;
    int          stall_cnt;
    int          error_cnt;
    logic        op_done;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk   (clk),
        .rst_o (rst_i)
    );

    ex_stage #(
        .MUL_LATENCY (MUL_LATENCY)
    ) UUT (
        .clk               (clk),
        .rst_i             (rst_i),
        .issue_valid_i     (issue_valid_i),
        .issue_op_i        (issue_op_i),
        .issue_pc_i        (issue_pc_i),
        .issue_rs1_i       (issue_rs1_i),
        .issue_rs2_i       (issue_rs2_i),
        .issue_imm_i       (issue_imm_i),
        .issue_rd_i        (issue_rd_i),
        .pred_taken_i      (pred_taken_i),
        .pred_target_i     (pred_target_i),
        .mem_addr_ok_i     (mem_addr_ok_i),
        .stall_o           (stall_o),
        .wb_valid_o        (wb_valid_o),
        .wb_rd_o           (wb_rd_o),
        .wb_data_o         (wb_data_o),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o),
        .mem_valid_o       (mem_valid_o),
        .mem_we_o          (mem_we_o),
        .mem_addr_o        (mem_addr_o),
        .mem_wdata_o       (mem_wdata_o),
        .mem_wstrb_o       (mem_wstrb_o),
        .exc_ale_o         (exc_ale_o)
    );

    // two lcg steps, upper halves only since the low bits repeat quickly
    function automatic logic [31:0] next_rand();
        logic [31:0] hi;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        hi        = rng_state;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {hi[31:16], rng_state[31:16]};
    endfunction

    // biased towards corner values
    function automatic logic [ex_pkg::XLEN-1:0] draw_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return '0;
            3'd1: return '1;
            3'd2: return 32'h8000_0000;
            3'd3: return {27'b0, r[7:3]};
            default: return next_rand();
        endcase
    endfunction

    function automatic void model_op(
        input  ex_pkg::alu_op_e op,
        input  logic [31:0]     pc, a, b, imm,
        input  logic            p_taken,
        input  logic [31:0]     p_target,
        output logic            wb_v,
        output logic [31:0]     wb_d,
        output logic            redir,
        output logic [31:0]     redir_tgt,
        output logic            mem_v,
        output logic [31:0]     addr, wdata,
        output logic [3:0]      strb,
        output logic            ale
    );
        logic [63:0] prod_s, prod_u;
        logic [31:0] a_mag, b_mag, quo, rem, target;
        logic        a_neg, b_neg, taken, is_br;
        prod_s = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        prod_u = {32'b0, a} * {32'b0, b};
        a_neg  = (op inside {ex_pkg::OP_DIVW, ex_pkg::OP_MODW}) && a[31];
        b_neg  = (op inside {ex_pkg::OP_DIVW, ex_pkg::OP_MODW}) && b[31];
        a_mag  = a_neg ? -a : a;
        b_mag  = b_neg ? -b : b;
        if (b == '0) begin
            quo = '1;
            rem = a;
        end else begin
            quo = (a_neg ^ b_neg) ? -(a_mag / b_mag) : a_mag / b_mag;
            rem = a_neg ? -(a_mag % b_mag) : a_mag % b_mag;
        end
        case (op)
            ex_pkg::OP_ADD:    wb_d = a + b;
            ex_pkg::OP_SUB:    wb_d = a - b;
            ex_pkg::OP_SLT:    wb_d = {31'b0, $signed(a) < $signed(b)};
            ex_pkg::OP_SLTU:   wb_d = {31'b0, a < b};
            ex_pkg::OP_AND:    wb_d = a & b;
            ex_pkg::OP_OR:     wb_d = a | b;
            ex_pkg::OP_XOR:    wb_d = a ^ b;
            ex_pkg::OP_NOR:    wb_d = ~(a | b);
            ex_pkg::OP_SLL:    wb_d = a << b[4:0];
            ex_pkg::OP_SRL:    wb_d = a >> b[4:0];
            ex_pkg::OP_SRA:    wb_d = $signed(a) >>> b[4:0];
            ex_pkg::OP_MULW:   wb_d = prod_s[31:0];
            ex_pkg::OP_MULHW:  wb_d = prod_s[63:32];
            ex_pkg::OP_MULHWU: wb_d = prod_u[63:32];
            ex_pkg::OP_DIVW, ex_pkg::OP_DIVWU: wb_d = quo;
            ex_pkg::OP_MODW, ex_pkg::OP_MODWU: wb_d = rem;
            default:           wb_d = pc + 32'd4;
        endcase
        wb_v = op inside {[ex_pkg::OP_ADD : ex_pkg::OP_MODWU], ex_pkg::OP_JIRL};
        case (op)
            ex_pkg::OP_BEQ:  taken = (a == b);
            ex_pkg::OP_BNE:  taken = (a != b);
            ex_pkg::OP_BLT:  taken = ($signed(a) < $signed(b));
            ex_pkg::OP_BGE:  taken = ($signed(a) >= $signed(b));
            ex_pkg::OP_BLTU: taken = (a < b);
            ex_pkg::OP_BGEU: taken = (a >= b);
            ex_pkg::OP_JIRL: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
        is_br     = op inside {[ex_pkg::OP_BEQ : ex_pkg::OP_JIRL]};
        target    = (op == ex_pkg::OP_JIRL) ? a + imm : pc + imm;
        redir     = is_br && ((taken != p_taken) || (taken && target != p_target));
        redir_tgt = taken ? target : pc + 32'd4;
        // memory request and lanes
        addr  = a + imm;
        wdata = '0;
        strb  = 4'b1111;
        ale   = 1'b0;
        case (op)
            ex_pkg::OP_LDH: ale = addr[0];
            ex_pkg::OP_LDW: ale = (addr[1:0] != 2'b00);
            ex_pkg::OP_STB: begin
                wdata = {4{b[7:0]}};
                strb  = 4'b0001 << addr[1:0];
            end
            ex_pkg::OP_STH: begin
                ale   = addr[0];
                wdata = {2{b[15:0]}};
                strb  = addr[1] ? 4'b1100 : 4'b0011;
            end
            ex_pkg::OP_STW: begin
                ale   = (addr[1:0] != 2'b00);
                wdata = b;
            end
            default: ale = 1'b0;
        endcase
        mem_v = (op inside {[ex_pkg::OP_LDB : ex_pkg::OP_STW]}) && !ale;
    endfunction

    task automatic report_error(input string msg);
        error_cnt++;
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_wb(input ex_pkg::alu_op_e op, input logic exp_valid,
                            input logic [4:0] exp_rd, input logic [ex_pkg::XLEN-1:0] exp_data);
        if (wb_valid_o !== exp_valid) begin
            report_error($sformatf("%s wb_valid expected %b got %b",
                                   op.name(), exp_valid, wb_valid_o));
        end else if (exp_valid && (wb_rd_o !== exp_rd || wb_data_o !== exp_data)) begin
            report_error($sformatf("%s rd/data expected %0d/%h got %0d/%h",
                                   op.name(), exp_rd, exp_data, wb_rd_o, wb_data_o));
        end
    endtask

    task automatic check_redirect(input ex_pkg::alu_op_e op, input logic exp_redir,
                                  input logic [ex_pkg::XLEN-1:0] exp_target);
        if (redirect_o !== exp_redir || (exp_redir && redirect_target_o !== exp_target)) begin
            report_error($sformatf("%s redirect/target expected %b/%h got %b/%h", op.name(),
                                   exp_redir, exp_target, redirect_o, redirect_target_o));
        end
    endtask

    task automatic check_mem(input ex_pkg::alu_op_e op, input logic exp_valid,
                             input logic exp_we, input logic [ex_pkg::XLEN-1:0] exp_addr,
                             input logic [ex_pkg::XLEN-1:0] exp_wdata,
                             input logic [3:0] exp_strb, input logic exp_ale);
        if (mem_valid_o !== exp_valid || exc_ale_o !== exp_ale) begin
            report_error($sformatf("%s mem_valid/ale expected %b/%b got %b/%b", op.name(),
                                   exp_valid, exp_ale, mem_valid_o, exc_ale_o));
        end else if (exp_valid && (mem_we_o !== exp_we || mem_addr_o !== exp_addr ||
                     mem_wstrb_o !== exp_strb || (exp_we && mem_wdata_o !== exp_wdata))) begin
            report_error($sformatf("%s we/addr/data/strb expected %b/%h/%h/%b got %b/%h/%h/%b",
                                   op.name(), exp_we, exp_addr, exp_wdata, exp_strb,
                                   mem_we_o, mem_addr_o, mem_wdata_o, mem_wstrb_o));
        end else if (exp_valid && stall_o !== !mem_addr_ok_i) begin
            report_error($sformatf("%s stall expected %b got %b",
                                   op.name(), !mem_addr_ok_i, stall_o));
        end
    endtask

    task automatic check_latency(input ex_pkg::alu_op_e op, input int waited);
        int expected;
        if (op inside {[ex_pkg::OP_MULW : ex_pkg::OP_MULHWU]}) begin
            expected = 1 + MUL_LATENCY;
        end else if (op inside {[ex_pkg::OP_DIVW : ex_pkg::OP_MODWU],
                                [ex_pkg::OP_LDB : ex_pkg::OP_STW]}) begin
            // variable latency, followed by done or by the cache
            expected = -1;
        end else begin
            expected = 0;
        end
        if (expected >= 0 && waited != expected) begin
            report_error($sformatf("%s stall cycles expected %0d got %0d",
                                   op.name(), expected, waited));
        end
    endtask

    task automatic draw_issue(input int n);
        logic [31:0] r;
        r = next_rand();
        issue_valid_i = 1'b1;
        issue_op_i    = ex_pkg::alu_op_e'(r[4:0]);
        issue_rd_i    = r[9:5];
        pred_taken_i  = r[10];
        issue_pc_i    = next_rand() & 32'hFFFF_FFFC;
        issue_rs1_i   = draw_operand();
        issue_rs2_i   = draw_operand();
        issue_imm_i   = draw_operand();
        // the first few ops are the divide corner cases
        if (n < 4) begin
            issue_op_i  = n[0] ? ex_pkg::OP_MODW : ex_pkg::OP_DIVW;
            issue_rs1_i = (n < 2) ? 32'h8000_0000 : issue_rs1_i;
            issue_rs2_i = (n < 2) ? 32'hFFFF_FFFF : 32'd0;
        end
        // half the time the front end guessed the target right
        pred_target_i = r[11] ? ((issue_op_i == ex_pkg::OP_JIRL) ? issue_rs1_i : issue_pc_i)
                                + issue_imm_i : next_rand();
    endtask

    // responses are sampled mid-cycle, well after the inputs settle
    always @(negedge clk) begin : compare_outputs
        logic        exp_wb_v, exp_redir, exp_mem_v, exp_ale;
        logic [31:0] exp_wb_d, exp_tgt, exp_addr, exp_wdata;
        logic [3:0]  exp_strb;
        op_done = 1'b0;
        if (!rst_i && !issue_valid_i) begin
            if (stall_o || wb_valid_o || redirect_o || mem_valid_o || exc_ale_o) begin
                report_error("status outputs active with no operation issued");
            end
        end else if (!rst_i) begin
            model_op(issue_op_i, issue_pc_i, issue_rs1_i, issue_rs2_i, issue_imm_i,
                     pred_taken_i, pred_target_i, exp_wb_v, exp_wb_d, exp_redir, exp_tgt,
                     exp_mem_v, exp_addr, exp_wdata, exp_strb, exp_ale);
            check_wb(issue_op_i, exp_wb_v && !stall_o, issue_rd_i, exp_wb_d);
            check_redirect(issue_op_i, exp_redir, exp_tgt);
            check_mem(issue_op_i, exp_mem_v, issue_op_i inside {[ex_pkg::OP_STB : ex_pkg::OP_STW]},
                      exp_addr, exp_wdata, exp_strb, exp_ale);
            if (!stall_o) begin
                check_latency(issue_op_i, stall_cnt);
                stall_cnt = 0;
                op_done   = 1'b1;
            end else begin
                stall_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped completing operations",
                     MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "run hung");
        end
    end

    initial begin : drive_ops
        int n;
        rng_state     = 32'd55892;
        stall_cnt     = 0;
        error_cnt     = 0;
        op_done       = 1'b0;
        issue_valid_i = 1'b0;
        issue_op_i    = ex_pkg::OP_NOP;
        issue_pc_i    = '0;
        issue_rs1_i   = '0;
        issue_rs2_i   = '0;
        issue_imm_i   = '0;
        issue_rd_i    = '0;
        pred_taken_i  = 1'b0;
        pred_target_i = '0;
        mem_addr_ok_i = 1'b0;
        @(negedge rst_i);
        @(posedge clk);
        for (n = 0; n < NUM_OPS; n++) begin
            #1;
            draw_issue(n);
            mem_addr_ok_i = (next_rand() % 3) != 0;
            @(posedge clk);
            // inputs stay put until the op completes, only the cache varies
            while (!op_done) begin
                #1;
                mem_addr_ok_i = (next_rand() % 3) != 0;
                @(posedge clk);
            end
        end
        #1;
        issue_valid_i = 1'b0;
        @(posedge clk);
        @(posedge clk);
        if (error_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "errors were found");
        end
    end

endmodule

// ==== project.f ====
ex_pkg.sv
regular_alu.sv
mul_alu.sv
div_alu.sv
branch_alu.sv
ex_stage.sv
tb_clock_gen.sv
ex_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	-$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
